/* run_sim.sh */
#!/usr/bin/env bash
# build tb_user_logic with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f vlog.f --top-module tb_user_logic -o tb_user_logic > sim.log 2>&1 \
   && ./obj_dir/tb_user_logic >> sim.log 2>&1 \
   || echo "build or simulation returned an error status" >> sim.log

cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

/* src/cfg_regs.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module cfg_regs (
   input  logic                   data_clk_i,
   input  logic                   data_rst_i,
   input  logic                   wr_i,
   input  logic                   rd_i,
   input  logic [`CFG_ADDR_W-1:0] addr_i,
   input  logic [`CFG_DATA_W-1:0] wdata_i,
   output logic [`CFG_DATA_W-1:0] rdata_o,
   output logic                   rvalid_o,
   output logic                   pattern_en_o,
   output dbt_pkg::sample_t       pattern_base_o
);
   import dbt_pkg::*;

   logic [`CFG_DATA_W-1:0] ctrl_q;
   logic [`CFG_DATA_W-1:0] base_q;
   logic [`CFG_DATA_W-1:0] scratch_q;
   logic [`CFG_DATA_W-1:0] rdata_q;
   logic                   rvalid_q;

   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         ctrl_q    <= '0;
         base_q    <= '0;
         scratch_q <= '0;
      end else if (wr_i) begin
         case (addr_i)
            `CFG_ADDR_CTRL:    ctrl_q    <= wdata_i;
            `CFG_ADDR_BASE:    base_q    <= wdata_i;
            `CFG_ADDR_SCRATCH: scratch_q <= wdata_i;
            default:           ;   // id and unmapped are read only
         endcase
      end
   end

   // readback, one cycle
   always_ff @(posedge data_clk_i) begin
      if (rd_i) begin
         case (addr_i)
            `CFG_ADDR_ID:      rdata_q <= `CFG_ID_VALUE;
            `CFG_ADDR_CTRL:    rdata_q <= ctrl_q;
            `CFG_ADDR_BASE:    rdata_q <= base_q;
            `CFG_ADDR_SCRATCH: rdata_q <= scratch_q;
            default:           rdata_q <= '0;
         endcase
      end
   end

   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_i;
      end
   end

   assign rdata_o        = rdata_q;
   assign rvalid_o       = rvalid_q;
   assign pattern_en_o   = ctrl_q[`CFG_CTRL_EN_BIT];
   assign pattern_base_o = sample_t'(base_q[`DBT_WORD_SIZE-1:0]);

endmodule

/* src/dbt_bus_extract.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module dbt_bus_extract (
   input  logic                  data_clk_i,
   input  logic                  data_rst_i,
   input  logic [`DBT_BUS_W-1:0] bus_i,
   dbt_chan_if.src               ch0_o,
   dbt_chan_if.src               ch1_o
);
   import dbt_pkg::*;

   logic [`DBT_CHANNELS-1:0][`DBT_CHAN_W-1:0] bus_q;   // one slot per channel

   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         bus_q <= '0;
      end else begin
         bus_q <= bus_i;
      end
   end

   // incoming user id is dropped, inserter writes its own
   assign ch0_o.valid     = bus_q[0][`DBT_OFS_VALID];
   assign ch0_o.rec_start = bus_q[0][`DBT_OFS_REC_START];
   assign ch0_o.rec_stop  = bus_q[0][`DBT_OFS_REC_STOP];
   assign ch0_o.rec_num   = bus_q[0][`DBT_OFS_RECNUM +: `DBT_RECNUM_W];
   assign ch0_o.data      = chan_data_u'(bus_q[0][`DBT_OFS_DATA +: `DBT_DATA_W]);

   assign ch1_o.valid     = bus_q[1][`DBT_OFS_VALID];
   assign ch1_o.rec_start = bus_q[1][`DBT_OFS_REC_START];
   assign ch1_o.rec_stop  = bus_q[1][`DBT_OFS_REC_STOP];
   assign ch1_o.rec_num   = bus_q[1][`DBT_OFS_RECNUM +: `DBT_RECNUM_W];
   assign ch1_o.data      = chan_data_u'(bus_q[1][`DBT_OFS_DATA +: `DBT_DATA_W]);

endmodule

/* src/dbt_bus_insert.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module dbt_bus_insert (
   dbt_chan_if.snk               ch0_i,
   dbt_chan_if.snk               ch1_i,
   output logic [`DBT_BUS_W-1:0] bus_o
);
   import dbt_pkg::*;

   logic [`DBT_CHANNELS-1:0][`DBT_CHAN_W-1:0] slot;

   function automatic logic [`DBT_CHAN_W-1:0] pack_slot(
      input logic                      valid,
      input logic                      rec_start,
      input logic                      rec_stop,
      input logic [`DBT_RECNUM_W-1:0]  rec_num,
      input logic [`DBT_USER_ID_W-1:0] user_id,
      input chan_data_u                data
   );
      logic [`DBT_CHAN_W-1:0] s;
      s = '0;   // reserved bits stay zero
      s[`DBT_OFS_DATA +: `DBT_DATA_W]       = data;
      s[`DBT_OFS_RECNUM +: `DBT_RECNUM_W]   = rec_num;
      s[`DBT_OFS_USER_ID +: `DBT_USER_ID_W] = user_id;
      s[`DBT_OFS_VALID]                     = valid;
      s[`DBT_OFS_REC_START]                 = rec_start;
      s[`DBT_OFS_REC_STOP]                  = rec_stop;
      return s;
   endfunction

   always_comb begin
      slot[0] = pack_slot(ch0_i.valid, ch0_i.rec_start, ch0_i.rec_stop,
                          ch0_i.rec_num, {`DBT_USER_ID_W{1'b0}}, ch0_i.data);
      slot[1] = pack_slot(ch1_i.valid, ch1_i.rec_start, ch1_i.rec_stop,
                          ch1_i.rec_num, `CH1_USER_ID, ch1_i.data);
   end

   assign bus_o = slot;

endmodule

/* src/dbt_chan_if.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

// one beat per clock, no handshake
interface dbt_chan_if;
   import dbt_pkg::*;

   logic                     valid;
   logic                     rec_start;
   logic                     rec_stop;
   logic [`DBT_RECNUM_W-1:0] rec_num;
   chan_data_u               data;

   modport src (
      output valid,
      output rec_start,
      output rec_stop,
      output rec_num,
      output data
   );

   modport snk (
      input valid,
      input rec_start,
      input rec_stop,
      input rec_num,
      input data
   );

endinterface

/* src/dbt_defines.svh */
`ifndef DBT_DEFINES_SVH
`define DBT_DEFINES_SVH

// bus geometry
`define DBT_CHANNELS      2
`define DBT_WORDS         8
`define DBT_WORD_SIZE     16
`define DBT_DATA_W        128
`define DBT_RECNUM_W      16
`define DBT_USER_ID_W     8
`define DBT_CHAN_W        160
`define DBT_BUS_W         320

// field offsets inside one channel slot
`define DBT_OFS_DATA      0
`define DBT_OFS_RECNUM    128
`define DBT_OFS_USER_ID   144
`define DBT_OFS_VALID     152
`define DBT_OFS_REC_START 153
`define DBT_OFS_REC_STOP  154
`define DBT_OFS_RSVD      155   // up to top of slot, always zero

// register file
`define CFG_ADDR_W        4
`define CFG_DATA_W        32
`define CFG_ADDR_ID       4'h0
`define CFG_ADDR_CTRL     4'h1
`define CFG_ADDR_BASE     4'h2
`define CFG_ADDR_SCRATCH  4'h3
`define CFG_CTRL_EN_BIT   31
`define CFG_ID_VALUE      32'h12345678

`define REC_TAG           64'hCAFACAFA_F1FA2025
`define CH1_USER_ID       8'hC1

`endif

/* src/dbt_pkg.sv */
`include "dbt_defines.svh"

package dbt_pkg;

   typedef logic [`DBT_WORD_SIZE-1:0] sample_t;

   // record info packet, tag in the low half
   typedef struct packed {
      logic [63:0] count;
      logic [63:0] tag;    // word 0 = tag[15:0]
   } rec_packet_t;

   // one channel data word, either raw samples or a record packet
   typedef union packed {
      sample_t [`DBT_WORDS-1:0] samples;
      rec_packet_t              pkt;
   } chan_data_u;

endpackage

/* src/pattern_gen.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module pattern_gen (
   input  logic             data_clk_i,
   input  logic             data_rst_i,
   input  logic             pattern_en_i,
   input  dbt_pkg::sample_t pattern_base_i,
   dbt_chan_if.snk          ch_i,
   dbt_chan_if.src          ch_o
);
   import dbt_pkg::*;

   chan_data_u pat_q;

   // ramp of base+k across the beat, wraps at 16 bits
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         pat_q <= '0;
      end else begin
         for (int k = 0; k < `DBT_WORDS; k++) begin
            pat_q.samples[k] <= pattern_base_i + sample_t'(k);
         end
      end
   end

   assign ch_o.valid     = ch_i.valid;
   assign ch_o.rec_start = ch_i.rec_start;
   assign ch_o.rec_stop  = ch_i.rec_stop;
   assign ch_o.rec_num   = ch_i.rec_num;
   assign ch_o.data      = pattern_en_i ? pat_q : ch_i.data;   // data mux

endmodule

/* src/record_info_gen.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module record_info_gen (
   input  logic    data_clk_i,
   input  logic    data_rst_i,
   dbt_chan_if.snk ch_i,
   input  logic    ch0_valid_i,
   dbt_chan_if.src ch_o
);
   import dbt_pkg::*;

   logic [63:0] rec_cnt_q;
   chan_data_u  pkt_data;

   // counts record starts seen on channel 1
   always_ff @(posedge data_clk_i) begin
      if (data_rst_i) begin
         rec_cnt_q <= '0;
      end else if (ch_i.rec_start) begin
         rec_cnt_q <= rec_cnt_q + 64'd1;
      end
   end

   // packet shows the count before this beat
   always_comb begin
      pkt_data.pkt.count = rec_cnt_q;
      pkt_data.pkt.tag   = `REC_TAG;
   end

   // channel 1 beats are marked valid with channel 0
   assign ch_o.valid     = ch0_valid_i;
   assign ch_o.rec_start = ch_i.rec_start;
   assign ch_o.rec_stop  = ch_i.rec_stop;
   assign ch_o.rec_num   = ch_i.rec_num;
   assign ch_o.data      = pkt_data;

endmodule

/* src/user_logic_top.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module user_logic_top (
   input  logic                   data_clk_i,
   input  logic                   data_rst_i,
   input  logic [`DBT_BUS_W-1:0]  bus_i,
   output logic [`DBT_BUS_W-1:0]  bus_o,
   input  logic                   cfg_wr_i,
   input  logic                   cfg_rd_i,
   input  logic [`CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`CFG_DATA_W-1:0] cfg_wdata_i,
   output logic [`CFG_DATA_W-1:0] cfg_rdata_o,
   output logic                   cfg_rvalid_o
);
   import dbt_pkg::*;

   logic    pattern_en;
   sample_t pattern_base;

   dbt_chan_if ch0_raw ();
   dbt_chan_if ch1_raw ();
   dbt_chan_if ch0_out ();
   dbt_chan_if ch1_out ();

   cfg_regs cfg_regs_inst (
      .data_clk_i     (data_clk_i),
      .data_rst_i     (data_rst_i),
      .wr_i           (cfg_wr_i),
      .rd_i           (cfg_rd_i),
      .addr_i         (cfg_addr_i),
      .wdata_i        (cfg_wdata_i),
      .rdata_o        (cfg_rdata_o),
      .rvalid_o       (cfg_rvalid_o),
      .pattern_en_o   (pattern_en),
      .pattern_base_o (pattern_base)
   );

   dbt_bus_extract dbt_bus_extract_inst (
      .data_clk_i (data_clk_i),
      .data_rst_i (data_rst_i),
      .bus_i      (bus_i),
      .ch0_o      (ch0_raw.src),
      .ch1_o      (ch1_raw.src)
   );

   pattern_gen pattern_gen_inst (
      .data_clk_i     (data_clk_i),
      .data_rst_i     (data_rst_i),
      .pattern_en_i   (pattern_en),
      .pattern_base_i (pattern_base),
      .ch_i           (ch0_raw.snk),
      .ch_o           (ch0_out.src)
   );

   record_info_gen record_info_gen_inst (
      .data_clk_i  (data_clk_i),
      .data_rst_i  (data_rst_i),
      .ch_i        (ch1_raw.snk),
      .ch0_valid_i (ch0_raw.valid),
      .ch_o        (ch1_out.src)
   );

   dbt_bus_insert dbt_bus_insert_inst (
      .ch0_i (ch0_out.snk),
      .ch1_i (ch1_out.snk),
      .bus_o (bus_o)
   );

endmodule

/* tests/tb_user_logic.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module tb_user_logic;
   import dbt_pkg::*;

   localparam int RD_TIMEOUT = 16;   // cycles

   logic                   data_clk;
   logic                   data_rst;
   logic [`DBT_BUS_W-1:0]  bus_in;
   logic [`DBT_BUS_W-1:0]  bus_out;
   logic                   cfg_wr;
   logic                   cfg_rd;
   logic [`CFG_ADDR_W-1:0] cfg_addr;
   logic [`CFG_DATA_W-1:0] cfg_wdata;
   logic [`CFG_DATA_W-1:0] cfg_rdata;
   logic                   cfg_rvalid;
   logic [63:0]            starts_driven;   // ch1 record starts since reset

   user_logic_top user_logic_top_inst (
      .data_clk_i   (data_clk),
      .data_rst_i   (data_rst),
      .bus_i        (bus_in),
      .bus_o        (bus_out),
      .cfg_wr_i     (cfg_wr),
      .cfg_rd_i     (cfg_rd),
      .cfg_addr_i   (cfg_addr),
      .cfg_wdata_i  (cfg_wdata),
      .cfg_rdata_o  (cfg_rdata),
      .cfg_rvalid_o (cfg_rvalid)
   );

   bind user_logic_top user_logic_sva user_logic_sva_inst (
      .data_clk_i   (data_clk_i),
      .data_rst_i   (data_rst_i),
      .cfg_rd_i     (cfg_rd_i),
      .cfg_rvalid_o (cfg_rvalid_o),
      .bus_o        (bus_o)
   );

   always #20 data_clk = ~data_clk;

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input chan_data_u got, input chan_data_u exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_user_id(input string name, input logic [`DBT_USER_ID_W-1:0] got,
                                input logic [`DBT_USER_ID_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_reg(input string name, input logic [`CFG_DATA_W-1:0] got,
                            input logic [`CFG_DATA_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_field(input string name, input logic [`DBT_RECNUM_W-1:0] got,
                              input logic [`DBT_RECNUM_W-1:0] exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   function automatic logic [`DBT_BUS_W-1:0] rand_word();
      logic [`DBT_BUS_W-1:0] w;
      for (int i = 0; i < `DBT_BUS_W / 32; i++)
         w[i*32 +: 32] = $urandom;
      return w;
   endfunction

   function automatic chan_data_u ch0_data_of(input logic [`DBT_BUS_W-1:0] w);
      return w[`DBT_OFS_DATA +: `DBT_DATA_W];
   endfunction

   // called on a falling edge, returns on the next one
   task automatic send_beat(input logic [`DBT_BUS_W-1:0] word,
                            output logic [`DBT_BUS_W-1:0] seen);
      bus_in = word;
      @(negedge data_clk);
      seen   = bus_out;
      bus_in = '0;   // idle unless another beat follows
      if (word[`DBT_CHAN_W + `DBT_OFS_REC_START])
         starts_driven++;
   endtask

   task automatic cfg_write(input logic [`CFG_ADDR_W-1:0] addr,
                            input logic [`CFG_DATA_W-1:0] data);
      cfg_wr    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(negedge data_clk);
      cfg_wr    = 1'b0;
   endtask

   task automatic cfg_read(input logic [`CFG_ADDR_W-1:0] addr,
                           output logic [`CFG_DATA_W-1:0] data);
      cfg_rd   = 1'b1;
      cfg_addr = addr;
      @(negedge data_clk);
      cfg_rd   = 1'b0;
      for (int n = 0; n < RD_TIMEOUT && cfg_rvalid !== 1'b1; n++)
         @(negedge data_clk);
      if (cfg_rvalid !== 1'b1)
         fail_now("register read got no rvalid before the timeout");
      data = cfg_rdata;
   endtask

   task automatic apply_reset(input int cycles);
      data_rst = 1'b1;
      bus_in   = '1;   // every valid and start bit set while held
      for (int c = 0; c < cycles; c++) begin
         @(negedge data_clk);
         for (int ch = 0; ch < `DBT_CHANNELS; ch++) begin
            check_flag($sformatf("ch%0d valid in reset", ch),
                       bus_out[ch*`DBT_CHAN_W + `DBT_OFS_VALID], 1'b0);
            check_flag($sformatf("ch%0d rec_start in reset", ch),
                       bus_out[ch*`DBT_CHAN_W + `DBT_OFS_REC_START], 1'b0);
         end
      end
      data_rst      = 1'b0;
      bus_in        = '0;
      starts_driven = '0;
   endtask

   task automatic check_beat(input logic [`DBT_BUS_W-1:0] word,
                             input logic [`DBT_BUS_W-1:0] seen,
                             input chan_data_u exp_ch0, input logic [63:0] exp_cnt);
      logic [`DBT_CHAN_W-1:0] in0;
      logic [`DBT_CHAN_W-1:0] in1;
      logic [`DBT_CHAN_W-1:0] out0;
      logic [`DBT_CHAN_W-1:0] out1;
      chan_data_u             exp_ch1;
      in0  = word[0 +: `DBT_CHAN_W];
      in1  = word[`DBT_CHAN_W +: `DBT_CHAN_W];
      out0 = seen[0 +: `DBT_CHAN_W];
      out1 = seen[`DBT_CHAN_W +: `DBT_CHAN_W];
      exp_ch1.pkt.count = exp_cnt;
      exp_ch1.pkt.tag   = `REC_TAG;
      check_data("ch0 data", out0[`DBT_OFS_DATA +: `DBT_DATA_W], exp_ch0);
      check_data("ch1 packet", out1[`DBT_OFS_DATA +: `DBT_DATA_W], exp_ch1);
      check_user_id("ch0 user id", out0[`DBT_OFS_USER_ID +: `DBT_USER_ID_W], '0);
      check_user_id("ch1 user id", out1[`DBT_OFS_USER_ID +: `DBT_USER_ID_W], `CH1_USER_ID);
      check_field("ch0 rec_num", out0[`DBT_OFS_RECNUM +: `DBT_RECNUM_W],
                  in0[`DBT_OFS_RECNUM +: `DBT_RECNUM_W]);
      check_field("ch1 rec_num", out1[`DBT_OFS_RECNUM +: `DBT_RECNUM_W],
                  in1[`DBT_OFS_RECNUM +: `DBT_RECNUM_W]);
      check_flag("ch0 valid", out0[`DBT_OFS_VALID], in0[`DBT_OFS_VALID]);
      check_flag("ch1 valid", out1[`DBT_OFS_VALID], in0[`DBT_OFS_VALID]);   // follows ch0
      check_flag("ch0 rec_start", out0[`DBT_OFS_REC_START], in0[`DBT_OFS_REC_START]);
      check_flag("ch1 rec_start", out1[`DBT_OFS_REC_START], in1[`DBT_OFS_REC_START]);
      check_flag("ch0 rec_stop", out0[`DBT_OFS_REC_STOP], in0[`DBT_OFS_REC_STOP]);
      check_flag("ch1 rec_stop", out1[`DBT_OFS_REC_STOP], in1[`DBT_OFS_REC_STOP]);
      check_field("ch0 reserved", 16'(out0[`DBT_CHAN_W-1:`DBT_OFS_RSVD]), '0);
      check_field("ch1 reserved", 16'(out1[`DBT_CHAN_W-1:`DBT_OFS_RSVD]), '0);
   endtask

   task automatic run_beat(input logic [`DBT_BUS_W-1:0] word, input chan_data_u exp_ch0);
      logic [`DBT_BUS_W-1:0] seen;
      logic [63:0]           exp_cnt;
      exp_cnt = starts_driven;   // starts on earlier beats only
      send_beat(word, seen);
      check_beat(word, seen, exp_ch0, exp_cnt);
   endtask

   task automatic test_registers();
      logic [`CFG_DATA_W-1:0] val;
      logic [`CFG_DATA_W-1:0] rd;
      cfg_read(`CFG_ADDR_ID, rd);
      check_reg("id register", rd, `CFG_ID_VALUE);
      for (int a = 1; a <= 3; a++) begin
         val = $urandom;
         cfg_write(4'(a), val);
         cfg_read(4'(a), rd);
         check_reg($sformatf("register %0d", a), rd, val);
      end
      cfg_read(4'h7, rd);
      check_reg("unmapped register 7", rd, '0);
      cfg_write(`CFG_ADDR_CTRL, '0);
   endtask

   task automatic test_pass_through();
      logic [`DBT_BUS_W-1:0] w;
      repeat (20) begin
         w = rand_word();
         run_beat(w, ch0_data_of(w));
      end
   endtask

   task automatic test_pattern();
      sample_t               base;
      chan_data_u            pat;
      logic [`DBT_BUS_W-1:0] w;
      logic [`DBT_BUS_W-1:0] seen;
      base = sample_t'($urandom);
      for (int k = 0; k < `DBT_WORDS; k++)
         pat.samples[k] = sample_t'(32'(base) + k);   // mod 65536
      cfg_write(`CFG_ADDR_BASE, {16'($urandom), base});
      cfg_write(`CFG_ADDR_CTRL, 32'h8000_0000);
      repeat (3) send_beat('0, seen);
      repeat (12) begin
         w = rand_word();
         run_beat(w, pat);
      end
      cfg_write(`CFG_ADDR_CTRL, '0);
      repeat (2) send_beat('0, seen);
      repeat (8) begin
         w = rand_word();
         run_beat(w, ch0_data_of(w));
      end
   endtask

   task automatic test_records();
      logic [`DBT_BUS_W-1:0] w;
      repeat (24) begin
         w = rand_word();
         w[`DBT_CHAN_W + `DBT_OFS_REC_START] = ($urandom_range(3) != 0);
         run_beat(w, ch0_data_of(w));
      end
   endtask

   task automatic test_ch1_valid();
      logic [`DBT_BUS_W-1:0] w;
      repeat (16) begin
         w = rand_word();
         w[`DBT_CHAN_W + `DBT_OFS_VALID] = ~w[`DBT_OFS_VALID];   // never agrees with ch0
         run_beat(w, ch0_data_of(w));
      end
   endtask

   task automatic test_reset();
      logic [`DBT_BUS_W-1:0] w;
      logic [`DBT_BUS_W-1:0] seen;
      logic [`CFG_DATA_W-1:0] rd;
      cfg_write(`CFG_ADDR_CTRL, 32'h8000_0000);
      repeat (4) begin
         w = rand_word();
         w[`DBT_CHAN_W + `DBT_OFS_REC_START] = 1'b1;
         send_beat(w, seen);
      end
      apply_reset(4);
      cfg_read(`CFG_ADDR_CTRL, rd);
      check_reg("ctrl after reset", rd, '0);
      cfg_read(`CFG_ADDR_BASE, rd);
      check_reg("base after reset", rd, '0);
      repeat (6) begin
         w = rand_word();
         run_beat(w, ch0_data_of(w));   // count restarts at zero
      end
   endtask

   initial begin
      void'($urandom(17));
      data_clk      = 1'b0;
      data_rst      = 1'b1;
      bus_in        = '0;
      cfg_wr        = 1'b0;
      cfg_rd        = 1'b0;
      cfg_addr      = '0;
      cfg_wdata     = '0;
      starts_driven = '0;
      apply_reset(8);
      test_registers();
      test_pass_through();
      test_pattern();
      test_records();
      test_ch1_valid();
      test_reset();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* tests/user_logic_sva.sv */
`timescale 1ns/1ps
`include "dbt_defines.svh"

module user_logic_sva (
   input logic                  data_clk_i,
   input logic                  data_rst_i,
   input logic                  cfg_rd_i,
   input logic                  cfg_rvalid_o,
   input logic [`DBT_BUS_W-1:0] bus_o
);

   localparam int CH1_BASE = `DBT_CHAN_W;   // ch1 slot offset

   // read response comes exactly one cycle after the request
   rvalid_after_rd: assert property (@(posedge data_clk_i) disable iff (data_rst_i)
      cfg_rd_i |=> cfg_rvalid_o)
      else $error("cfg_rvalid_o missing one cycle after a read request");

   rvalid_only_after_rd: assert property (@(posedge data_clk_i) disable iff (data_rst_i)
      !cfg_rd_i |=> !cfg_rvalid_o)
      else $error("cfg_rvalid_o high without a read request");

   ch1_user_id_fixed: assert property (@(posedge data_clk_i)
      bus_o[CH1_BASE + `DBT_OFS_USER_ID +: `DBT_USER_ID_W] == `CH1_USER_ID)
      else $error("channel 1 user id at bus_o is not the fixed id");

   // extract regs are cleared by the first reset edge
   quiet_in_reset: assert property (@(posedge data_clk_i)
      data_rst_i |=> (bus_o[`DBT_OFS_VALID] == 1'b0 &&
                      bus_o[`DBT_OFS_REC_START] == 1'b0 &&
                      bus_o[CH1_BASE + `DBT_OFS_VALID] == 1'b0 &&
                      bus_o[CH1_BASE + `DBT_OFS_REC_START] == 1'b0))
      else $error("bus_o valid or start bit set while reset is held");

endmodule

/* vlog.f */
+incdir+src
src/dbt_pkg.sv
src/dbt_chan_if.sv
src/cfg_regs.sv
src/dbt_bus_extract.sv
src/pattern_gen.sv
src/record_info_gen.sv
src/dbt_bus_insert.sv
src/user_logic_top.sv
tests/user_logic_sva.sv
tests/tb_user_logic.sv
